// ==== zc_expander.f ====
+incdir+include
source/zc_pkg.sv
source/cm_classifier.sv
source/cmd_fifo.sv
source/cm_sequencer.sv
source/zc_expander.sv
verification/tb_zc_expander.sv

// ==== Makefile ====
# Verilator flow for the Zcmp expander testbench
VERILATOR ?= verilator
TOP       ?= tb_zc_expander
FILELIST  ?= zc_expander.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_zc_expander.sv ====
//////////////////////////////
// Testbench for zc_expander with a fixed seed and random ready
// Sends only while holding a credit
// Expected stream comes from a local model
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_zc_expander;
  import zc_pkg::*;

  localparam int unsigned FIFO_DEPTH     = FIFO_DEPTH_DEFAULT;
  localparam int unsigned SEED           = 32'h667a620c;
  localparam int          N_DIRECTED     = 12;
  localparam int          NUM_WORDS      = 400;
  // 200 cycles per word sent
  localparam int          TIMEOUT_CYCLES = NUM_WORDS * 200;

  logic     clk_i;
  logic     rst_ni;
  logic     in_valid_i;
  instr_t   in_instr_i;
  logic     credit_o;
  logic     out_valid_o;
  exp_out_t out_o;
  logic     out_ready_i;

  exp_out_t exp_q[$];
  int       credits;
  int       sent;
  int       cycles;
  logic     any_sent;

  zc_expander #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_instr_i  (in_instr_i),
    .credit_o    (credit_o),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "check failed");
  endtask

  //////////////////////////////
  // RV32 encoders for the model
  //////////////////////////////
  function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // sw rs2, imm(rs1)
  function automatic instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  // Register i of the list counted from the bottom: ra, s0, s1, s2..s11
  function automatic logic [4:0] list_reg(input int i);
    if (i == 0) return 5'd1;
    if (i < 3) return 5'(7 + i);
    return 5'(15 + i);
  endfunction

  function automatic logic [4:0] s_reg(input logic [2:0] r);
    return (r < 3'd2) ? 5'd8 + 5'(r) : 5'd16 + 5'(r);
  endfunction

  task automatic add_expected(input instr_t instr, input logic is_c, input logic ill,
                              input logic last);
    exp_out_t e;
    e.instr         = instr;
    e.is_compressed = is_c;
    e.illegal       = ill;
    e.last          = last;
    exp_q.push_back(e);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  task automatic expand_word(input instr_t w);
    int   n;
    int   adj;
    int   rl;
    logic is_pp;
    logic is_mv;
    // push/pop family with a legal list
    is_pp = (w[1:0] == 2'b10) && (w[15:11] == 5'b10111) && !w[8] && (w[7:4] >= 4'd4);
    // mv pairs need distinct s-registers
    is_mv = (w[1:0] == 2'b10) && (w[15:10] == 6'b101011) && w[5] && (w[9:7] != w[4:2]);
    if (w[1:0] == 2'b11) begin
      add_expected(w, 1'b0, 1'b0, 1'b1);
    end else if (is_pp) begin
      rl  = int'(w[7:4]);
      n   = (rl == 15) ? 13 : rl - 3;
      adj = (rl <= 7) ? 16 : (rl <= 11) ? 32 : (rl <= 14) ? 48 : 64;
      adj = adj + 16 * int'(w[3:2]);
      // Top of the list first
      for (int k = 1; k <= n; k++) begin
        if (w[10:9] == 2'b00) begin
          add_expected(enc_s(12'(-4 * k), list_reg(n - k), 5'd2), 1'b1, 1'b0, 1'b0);
        end else begin
          add_expected(enc_i(12'(adj - 4 * k), 5'd2, 3'b010, list_reg(n - k), 7'h03),
                       1'b1, 1'b0, 1'b0);
        end
      end
      if (w[10:9] == 2'b00) begin
        add_expected(enc_i(12'(-adj), 5'd2, 3'b000, 5'd2, 7'h13), 1'b1, 1'b0, 1'b1);
      end else begin
        add_expected(enc_i(12'(adj), 5'd2, 3'b000, 5'd2, 7'h13), 1'b1, 1'b0,
                     w[10:9] == 2'b01);
        // popretz clears a0 before the return
        if (w[10:9] == 2'b10) begin
          add_expected(enc_i(12'd0, 5'd0, 3'b000, 5'd10, 7'h13), 1'b1, 1'b0, 1'b0);
        end
        if (w[10]) begin
          add_expected(enc_i(12'd0, 5'd1, 3'b000, 5'd0, 7'h67), 1'b1, 1'b0, 1'b1);
        end
      end
    end else if (is_mv) begin
      if (!w[6]) begin
        add_expected(enc_i(12'd0, 5'd10, 3'b000, s_reg(w[9:7]), 7'h13), 1'b1, 1'b0, 1'b0);
        add_expected(enc_i(12'd0, 5'd11, 3'b000, s_reg(w[4:2]), 7'h13), 1'b1, 1'b0, 1'b1);
      end else begin
        add_expected(enc_i(12'd0, s_reg(w[9:7]), 3'b000, 5'd10, 7'h13), 1'b1, 1'b0, 1'b0);
        add_expected(enc_i(12'd0, s_reg(w[4:2]), 3'b000, 5'd11, 7'h13), 1'b1, 1'b0, 1'b1);
      end
    end else begin
      add_expected(w, 1'b1, 1'b1, 1'b1);
    end
  endtask

  //////////////////////////////
  // Stimulus words
  //////////////////////////////
  // sel 00 push, 01 pop, 10 popretz, 11 popret
  function automatic logic [15:0] pp_word(input logic [1:0] sel, input logic [3:0] rl,
                                          input logic [1:0] spimm);
    return {3'b101, 2'b11, sel, 1'b0, rl, spimm, 2'b10};
  endfunction

  // op 01 mvsa01, 11 mva01s, others are illegal
  function automatic logic [15:0] mv_word(input logic [1:0] op, input logic [2:0] r1,
                                          input logic [2:0] r2);
    return {3'b101, 3'b011, r1, op, r2, 2'b10};
  endfunction

  // Edge lists, max spimm and illegal corners first
  function automatic instr_t directed_word(input int idx);
    case (idx)
      0:       return {16'h0, pp_word(2'b00, 4'd4, 2'd0)};
      1:       return {16'h0, pp_word(2'b00, 4'd15, 2'd3)};
      2:       return {16'h0, pp_word(2'b01, 4'd15, 2'd3)};
      3:       return {16'h0, pp_word(2'b11, 4'd4, 2'd0)};
      4:       return {16'h0, pp_word(2'b10, 4'd15, 2'd3)};
      5:       return {16'h0, pp_word(2'b11, 4'd8, 2'd1)};
      6:       return {16'h0, mv_word(2'b01, 3'd0, 3'd7)};
      7:       return {16'h0, mv_word(2'b11, 3'd3, 3'd1)};
      8:       return {16'h0, pp_word(2'b00, 4'd3, 2'd2)};
      9:       return {16'h0, mv_word(2'b01, 3'd2, 3'd2)};
      10:      return 32'h0000_0505;
      default: return 32'h0010_0093;
    endcase
  endfunction

  function automatic instr_t random_word();
    instr_t w;
    int     cls;
    w   = $urandom();
    cls = int'($urandom_range(0, 4));
    case (cls)
      0: w[1:0] = 2'b11;
      1, 2: begin
        w[15:0] = pp_word(2'($urandom_range(0, 3)), 4'($urandom_range(0, 15)),
                          2'($urandom_range(0, 3)));
      end
      3: begin
        w[15:0] = mv_word(2'($urandom_range(0, 3)), 3'($urandom_range(0, 7)),
                          3'($urandom_range(0, 7)));
      end
      // Any other 16-bit encoding
      default: w[1:0] = 2'($urandom_range(0, 2));
    endcase
    return w;
  endfunction

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin : main
    instr_t word;
    void'($urandom(SEED));
    rst_ni      = 1'b0;
    in_valid_i  = 1'b0;
    in_instr_i  = '0;
    out_ready_i = 1'b0;
    credits     = int'(FIFO_DEPTH);
    sent        = 0;
    any_sent    = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Run until all words drained and every credit is back
    while (sent < NUM_WORDS || exp_q.size() != 0 || credits != int'(FIFO_DEPTH)) begin
      @(posedge clk_i);
      if (credit_o) credits++;
      assert (credits <= int'(FIFO_DEPTH))
        else report_error($sformatf("credit count %0d above depth", credits));
      out_ready_i <= ($urandom_range(0, 3) != 0);
      if (sent < NUM_WORDS && credits > 0 && $urandom_range(0, 4) != 0) begin
        word = (sent < N_DIRECTED) ? directed_word(sent) : random_word();
        in_valid_i <= 1'b1;
        in_instr_i <= word;
        expand_word(word);
        credits--;
        sent++;
        any_sent = 1'b1;
      end else begin
        in_valid_i <= 1'b0;
      end
    end
    $display("Test OK");
    $finish;
  end

  //////////////////////////////
  // Output checks
  //////////////////////////////
  always @(posedge clk_i) begin : check_out
    exp_out_t want;
    if (rst_ni && out_valid_o && out_ready_i) begin
      assert (exp_q.size() != 0)
        else report_error("instruction accepted with none expected");
      want = exp_q.pop_front();
      assert (out_o == want)
        else report_error($sformatf("out_o %h c%0b i%0b l%0b, expected %h c%0b i%0b l%0b",
                                    out_o.instr, out_o.is_compressed, out_o.illegal,
                                    out_o.last, want.instr, want.is_compressed,
                                    want.illegal, want.last));
    end
  end

  // Quiet outputs until the first word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !any_sent |-> !out_valid_o && !credit_o)
    else report_error("output activity before any word was sent");

  // Stalled output holds
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o))
    else report_error("out_o changed while stalled");

  // Watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not drain within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  initial cycles = 0;

endmodule

`default_nettype wire

// ==== source/zc_expander.sv ====
//////////////////////////////
// Zcmp expander top level
// Fetch side holds FIFO_DEPTH credits after reset
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module zc_expander #(
  parameter int unsigned FIFO_DEPTH = zc_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             in_valid_i,
  input  zc_pkg::instr_t   in_instr_i,
  output logic             credit_o,
  output logic             out_valid_o,
  output zc_pkg::exp_out_t out_o,
  input  logic             out_ready_i
);
  import zc_pkg::*;

  // Classifier to FIFO
  logic    cmd_valid;
  cm_cmd_t cmd;
  // FIFO to sequencer
  cm_cmd_t head;
  logic    head_valid;
  logic    pop;

  cm_classifier u_classifier (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_instr_i  (in_instr_i),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd)
  );

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (cmd_valid),
    .cmd_i        (cmd),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .credit_o     (credit_o)
  );

  cm_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .head_valid_i (head_valid),
    .pop_o        (pop),
    .out_valid_o  (out_valid_o),
    .out_o        (out_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

`default_nettype wire

// ==== source/cm_sequencer.sv ====
//////////////////////////////
// Expands the FIFO head into RV32 instructions
// Output is registered, one instruction per accepted handshake
// Head stays in the FIFO until its last instruction loads
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cm_sequencer (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  zc_pkg::cm_cmd_t  head_i,
  input  logic             head_valid_i,
  output logic             pop_o,
  output logic             out_valid_o,
  output zc_pkg::exp_out_t out_o,
  input  logic             out_ready_i
);
  import zc_pkg::*;

  `include "zcmp_encode.svh"

  typedef enum logic [3:0] {
    Idle,
    PushStore,
    PushDecrSp,
    PopLoad,
    PopIncrSp,
    PopZeroA0,
    PopRetRa,
    MvFirst,
    MvSecond
  } seq_state_e;

  seq_state_e state_d, state_q;
  rlist_t     rlist_d, rlist_q;
  sp_off_t    sp_off_d, sp_off_q;
  exp_out_t   out_d, out_q;
  logic       out_valid_q;
  logic       emit;
  logic       load_en;

  // Output register free or draining this cycle
  assign load_en = !out_valid_q || out_ready_i;

  //////////////////////////////
  // Next instruction
  //////////////////////////////
  always_comb begin
    state_d  = state_q;
    rlist_d  = rlist_q;
    sp_off_d = sp_off_q;
    emit     = 1'b0;
    out_d.instr         = head_i.instr;
    out_d.is_compressed = (head_i.instr[1:0] != 2'b11);
    out_d.illegal       = 1'b0;
    out_d.last          = 1'b0;

    case (state_q)
      Idle: begin
        if (head_valid_i) begin
          rlist_d = head_i.rlist;
          case (head_i.kind)
            KindPush: begin
              // First store goes to -4(sp)
              sp_off_d = 5'd1;
              state_d  = PushStore;
            end
            KindPop, KindPopRet, KindPopRetZ: begin
              // Top register sits just below the new sp
              sp_off_d = cm_stack_adj_word(head_i.rlist, head_i.spimm) - 5'd1;
              state_d  = PopLoad;
            end
            KindMvsa01, KindMva01s: state_d = MvFirst;
            default: begin
              // Plain or illegal word leaves as is
              emit          = 1'b1;
              out_d.illegal = (head_i.kind == KindIllegal);
              out_d.last    = 1'b1;
            end
          endcase
        end
      end
      PushStore: begin
        emit        = 1'b1;
        out_d.instr = cm_push_store(rlist_q, sp_off_q);
        if (load_en) begin
          rlist_d  = rlist_q - 5'd1;
          sp_off_d = sp_off_q + 5'd1;
          // ra is always the bottom of the list
          if (rlist_q == 5'd4) state_d = PushDecrSp;
        end
      end
      PushDecrSp: begin
        emit        = 1'b1;
        out_d.instr = cm_sp_addi(head_i.rlist, head_i.spimm, 1'b1);
        out_d.last  = 1'b1;
        if (load_en) state_d = Idle;
      end
      PopLoad: begin
        emit        = 1'b1;
        out_d.instr = cm_pop_load(rlist_q, sp_off_q);
        if (load_en) begin
          rlist_d  = rlist_q - 5'd1;
          sp_off_d = sp_off_q - 5'd1;
          if (rlist_q == 5'd4) state_d = PopIncrSp;
        end
      end
      PopIncrSp: begin
        emit        = 1'b1;
        out_d.instr = cm_sp_addi(head_i.rlist, head_i.spimm, 1'b0);
        out_d.last  = (head_i.kind == KindPop);
        if (load_en) begin
          case (head_i.kind)
            KindPopRetZ: state_d = PopZeroA0;
            KindPopRet:  state_d = PopRetRa;
            default:     state_d = Idle;
          endcase
        end
      end
      PopZeroA0: begin
        emit        = 1'b1;
        out_d.instr = cm_zero_a0();
        if (load_en) state_d = PopRetRa;
      end
      PopRetRa: begin
        emit        = 1'b1;
        out_d.instr = cm_ret_ra();
        out_d.last  = 1'b1;
        if (load_en) state_d = Idle;
      end
      MvFirst: begin
        emit = 1'b1;
        // a0 pairs with r1s
        if (head_i.kind == KindMvsa01) out_d.instr = cm_mv(cm_sreg(head_i.r1s), REG_A0);
        else                           out_d.instr = cm_mv(REG_A0, cm_sreg(head_i.r1s));
        if (load_en) state_d = MvSecond;
      end
      MvSecond: begin
        emit       = 1'b1;
        out_d.last = 1'b1;
        // a1 pairs with r2s
        if (head_i.kind == KindMvsa01) out_d.instr = cm_mv(cm_sreg(head_i.r2s), REG_A0 + 5'd1);
        else                           out_d.instr = cm_mv(REG_A0 + 5'd1, cm_sreg(head_i.r2s));
        if (load_en) state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  // Retire the command with its final instruction
  assign pop_o = emit && out_d.last && load_en;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      rlist_q     <= '0;
      sp_off_q    <= '0;
      out_valid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rlist_q  <= rlist_d;
      sp_off_q <= sp_off_d;
      if (load_en) out_valid_q <= emit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en && emit) begin
      out_q <= out_d;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

  // Stalled output holds until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

`default_nettype wire

// ==== source/cmd_fifo.sv ====
//////////////////////////////
// Command FIFO, head read combinationally
// One registered credit pulse per pop
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cmd_fifo #(
  parameter int unsigned FIFO_DEPTH = zc_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  zc_pkg::cm_cmd_t  cmd_i,
  input  logic             pop_i,
  output zc_pkg::cm_cmd_t  head_o,
  output logic             head_valid_o,
  output logic             credit_o
);
  import zc_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  cm_cmd_t          mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             credit_q;

  // Storage, no reset
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      // Wrap explicitly so any depth works
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) count_q <= count_q + 1'b1;
      if (pop_i && !push_i) count_q <= count_q - 1'b1;
      credit_q <= pop_i;
    end
  end

  assign head_o       = mem[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign credit_o     = credit_q;

  // Credit loop keeps the FIFO from overflowing
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> count_q != CNT_W'(FIFO_DEPTH));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> count_q != '0);

endmodule

`default_nettype wire

// ==== source/cm_classifier.sv ====
//////////////////////////////
// Word classifier with one cycle from in_valid_i to cmd_valid_o
// Never stalls since the credit loop bounds the input rate
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cm_classifier (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             in_valid_i,
  input  zc_pkg::instr_t   in_instr_i,
  output logic             cmd_valid_o,
  output zc_pkg::cm_cmd_t  cmd_o
);
  import zc_pkg::*;

  cm_cmd_t cmd_d;
  cm_cmd_t cmd_q;
  logic    cmd_valid_q;
  logic    rlist_rsvd;
  logic    mv_same;

  // Codes 0..3 are reserved for push/pop
  assign rlist_rsvd = (in_instr_i[7:4] < 4'd4);
  // mv pairs need two distinct s-registers
  assign mv_same    = (in_instr_i[9:7] == in_instr_i[4:2]);

  //////////////////////////////
  // Decode
  //////////////////////////////
  always_comb begin
    cmd_d.instr = in_instr_i;
    cmd_d.spimm = in_instr_i[3:2];
    cmd_d.r1s   = in_instr_i[9:7];
    cmd_d.r2s   = in_instr_i[4:2];
    // x26/x27 pair handled as list 16
    cmd_d.rlist = (in_instr_i[7:4] == 4'hf) ? 5'd16 : {1'b0, in_instr_i[7:4]};
    cmd_d.kind  = KindIllegal;

    if (in_instr_i[1:0] == 2'b11) begin
      cmd_d.kind = KindPlain;
    end else if (in_instr_i[1:0] == 2'b10 && in_instr_i[15:13] == 3'b101) begin
      // C2 funct3 101 with funct5 picking the Zcmp op
      casez (in_instr_i[12:8])
        5'b11000: cmd_d.kind = rlist_rsvd ? KindIllegal : KindPush;
        5'b11010: cmd_d.kind = rlist_rsvd ? KindIllegal : KindPop;
        5'b11100: cmd_d.kind = rlist_rsvd ? KindIllegal : KindPopRetZ;
        5'b11110: cmd_d.kind = rlist_rsvd ? KindIllegal : KindPopRet;
        5'b011??: begin
          if (!mv_same && in_instr_i[6:5] == 2'b01) cmd_d.kind = KindMvsa01;
          if (!mv_same && in_instr_i[6:5] == 2'b11) cmd_d.kind = KindMva01s;
        end
        default: cmd_d.kind = KindIllegal;
      endcase
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= in_valid_i;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      cmd_q <= cmd_d;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = cmd_q;

  // Fetch side must present known data with valid
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(in_valid_i) && (!in_valid_i || !$isunknown(in_instr_i)));

endmodule

`default_nettype wire

// ==== source/zc_pkg.sv ====
//////////////////////////////
// Shared types and constants for the Zcmp expander
// List code 15 is carried internally as 16 (s10 and s11)
//////////////////////////////
`default_nettype none

package zc_pkg;

  // Plain vector types
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  // Internal register-list code, 15 widened to 16
  typedef logic [4:0]  rlist_t;
  typedef logic [1:0]  spimm_t;
  // Word offset from sp
  typedef logic [4:0]  sp_off_t;

  // Command classes seen by the sequencer
  typedef enum logic [2:0] {
    KindPlain,
    KindIllegal,
    KindPush,
    KindPop,
    KindPopRet,
    KindPopRetZ,
    KindMvsa01,
    KindMva01s
  } cmd_kind_e;

  // Classified word as stored in the FIFO
  typedef struct packed {
    cmd_kind_e  kind;
    rlist_t     rlist;
    spimm_t     spimm;
    logic [2:0] r1s;
    logic [2:0] r2s;
    instr_t     instr;
  } cm_cmd_t;

  // One instruction towards decode
  typedef struct packed {
    instr_t instr;
    logic   is_compressed;
    logic   illegal;
    logic   last;
  } exp_out_t;

  // RV32 major opcodes used by the expansions
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_OP_IMM = 7'h13;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;

  // ABI registers
  localparam reg_idx_t REG_RA = 5'd1;
  localparam reg_idx_t REG_SP = 5'd2;
  localparam reg_idx_t REG_A0 = 5'd10;

  localparam int unsigned FIFO_DEPTH_DEFAULT = 4;

endpackage

`default_nettype wire

// ==== include/zcmp_encode.svh ====
//////////////////////////////
// RV32 encoders for Zcmp sequences
// Include inside a module body after the zc_pkg import
// Reserved list codes below 4 are never passed in
//////////////////////////////
`ifndef ZCMP_ENCODE_SVH
`define ZCMP_ENCODE_SVH

// Stack adjustment in words, base from the list plus 4 words per spimm step
function automatic sp_off_t cm_stack_adj_word(input rlist_t rlist, input spimm_t spimm);
  sp_off_t base;
  case (rlist)
    5'd4, 5'd5, 5'd6, 5'd7:   base = 5'd4;
    5'd8, 5'd9, 5'd10, 5'd11: base = 5'd8;
    5'd12, 5'd13, 5'd14:      base = 5'd12;
    5'd16:                    base = 5'd16;
    default:                  base = 5'd0;
  endcase
  return base + {1'b0, spimm, 2'b00};
endfunction

// Highest register still in the list
function automatic reg_idx_t cm_rlist_top_reg(input rlist_t rlist);
  // 7..16 map onto s2..s11 (x18..x27)
  if (rlist >= 5'd7) return rlist + 5'd11;
  // s0 and s1
  if (rlist >= 5'd5) return rlist + 5'd3;
  return REG_RA;
endfunction

// s-register named by a 3-bit r1s/r2s field
function automatic reg_idx_t cm_sreg(input logic [2:0] rs);
  if (rs < 3'd2) return 5'd8 + {2'b00, rs};
  return 5'd16 + {2'b00, rs};
endfunction

// Generic addi rd, rs1, imm
function automatic instr_t cm_addi(input reg_idx_t dst, input reg_idx_t src,
                                   input logic [11:0] imm);
  return {imm, src, 3'b000, dst, OPCODE_OP_IMM};
endfunction

// sw top, -4*off(sp)
function automatic instr_t cm_push_store(input rlist_t rlist, input sp_off_t sp_off);
  logic [11:0] imm;
  imm = 12'd0 - {5'b00000, sp_off, 2'b00};
  return {imm[11:5], cm_rlist_top_reg(rlist), REG_SP, 3'b010, imm[4:0], OPCODE_STORE};
endfunction

// lw top, 4*off(sp)
function automatic instr_t cm_pop_load(input rlist_t rlist, input sp_off_t sp_off);
  return {5'b00000, sp_off, 2'b00, REG_SP, 3'b010, cm_rlist_top_reg(rlist), OPCODE_LOAD};
endfunction

// addi sp, sp, +/- stack adjustment
function automatic instr_t cm_sp_addi(input rlist_t rlist, input spimm_t spimm,
                                      input logic decr);
  logic [11:0] imm;
  imm = {5'b00000, cm_stack_adj_word(rlist, spimm), 2'b00};
  if (decr) imm = 12'd0 - imm;
  return cm_addi(REG_SP, REG_SP, imm);
endfunction

// mv dst, src
function automatic instr_t cm_mv(input reg_idx_t dst, input reg_idx_t src);
  return cm_addi(dst, src, 12'd0);
endfunction

// addi a0, x0, 0
function automatic instr_t cm_zero_a0();
  return cm_addi(REG_A0, 5'd0, 12'd0);
endfunction

// jalr x0, 0(ra)
function automatic instr_t cm_ret_ra();
  return {12'd0, REG_RA, 3'b000, 5'd0, OPCODE_JALR};
endfunction

`endif
